// File: runSim.sh
#!/bin/sh
# build with Verilator, run, and decide on the log contents
rm -f sim.log &&
verilator --binary --timing --assert --top-module tbMipsCore -f tb.f > build.log 2>&1 &&
./obj_dir/VtbMipsCore > sim.log 2>&1 ||
echo "build or run returned an error, see build.log and sim.log"
grep -q "Simulation PASSED" sim.log && echo "pass message found in sim.log" || exit 1

// File: src/decodeStage.sv
module decodeStage (
	input logic clk,
	input logic rst,
	input mipsPkg::fetchData_t fetchIn,
	output mipsPkg::regAddr_t rs,
	output mipsPkg::regAddr_t rt,
	input mipsPkg::word_t regA,
	input mipsPkg::word_t regB,
	input mipsPkg::fwdSel_t fwdSelA,
	input mipsPkg::fwdSel_t fwdSelB,
	input mipsPkg::word_t execResult,
	input mipsPkg::retire_t retireIn,
	output logic redirect,
	output mipsPkg::word_t target,
	output mipsPkg::decodeData_t decodeOut
);
	import mipsPkg::*;

	ctl_t ctl;
	regAddr_t rd;
	logic [4:0] shamt;
	logic [15:0] imm16;
	logic [25:0] index;
	word_t extImm;
	word_t srcA;
	word_t srcB;
	word_t pcPlus4;
	word_t branchTarget;
	word_t jumpTarget;
	logic branchTaken;
	regAddr_t dst;

	mainDecoder u_mainDecoder (
		.instr(fetchIn.instr),
		.ctl(ctl)
	);

	// field split
	assign rs = fetchIn.instr[25:21];
	assign rt = fetchIn.instr[20:16];
	assign rd = fetchIn.instr[15:11];
	assign shamt = fetchIn.instr[10:6];
	assign imm16 = fetchIn.instr[15:0];
	assign index = fetchIn.instr[25:0];

	assign extImm = ctl.zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

	// operands in flight come from execute or writeback
	always_comb begin
		case (fwdSelA)
			FWD_EXEC: srcA = execResult;
			FWD_WB: srcA = retireIn.wdata;
			default: srcA = regA;
		endcase
		case (fwdSelB)
			FWD_EXEC: srcB = execResult;
			FWD_WB: srcB = retireIn.wdata;
			default: srcB = regB;
		endcase
	end

	always_comb begin
		case (ctl.branchType)
			BR_EQ: branchTaken = (srcA == srcB);
			BR_NE: branchTaken = (srcA != srcB);
			default: branchTaken = 1'b0;
		endcase
	end

	// targets are relative to the delay slot address
	assign pcPlus4 = fetchIn.pc + 32'd4;
	assign branchTarget = pcPlus4 + {extImm[29:0], 2'b00};
	assign jumpTarget = {pcPlus4[31:28], index, 2'b00};

	always_comb begin
		if (ctl.jr) begin
			target = srcA;
		end else if (ctl.jump) begin
			target = jumpTarget;
		end else begin
			target = branchTarget;
		end
	end

	assign redirect = fetchIn.valid && (branchTaken || ctl.jump || ctl.jr);

	always_comb begin
		if (ctl.link) begin
			dst = LINK_REG;
		end else if (ctl.dstIsRt) begin
			dst = rt;
		end else begin
			dst = rd;
		end
	end

	always_comb begin
		decodeOut.valid = fetchIn.valid;
		decodeOut.pc = fetchIn.pc;
		decodeOut.ctl = ctl;
		decodeOut.srcA = srcA;
		decodeOut.srcB = srcB;
		decodeOut.extImm = extImm;
		decodeOut.shamt = shamt;
		decodeOut.dst = dst;
		decodeOut.reserved = ctl.reserved;
	end

endmodule

// File: src/executeStage.sv
module executeStage (
	input logic clk,
	input logic rst,
	input mipsPkg::decodeData_t decodeIn,
	output mipsPkg::regAddr_t execDst,
	output logic execWrite,
	output mipsPkg::word_t execResult,
	output mipsPkg::retire_t retire
);
	import mipsPkg::*;

	decodeData_t deReg;
	word_t opA;
	word_t opB;
	logic [4:0] shiftAmt;
	word_t aluOut;

	// decode/execute register
	always_ff @(posedge clk) begin
		if (rst) begin
			deReg <= '0;
		end else begin
			deReg <= decodeIn;
		end
	end

	assign opA = deReg.srcA;
	// link address enters as operand b
	assign opB = deReg.ctl.link ? deReg.pc + 32'd8 :
		deReg.ctl.useImm ? deReg.extImm : deReg.srcB;
	assign shiftAmt = deReg.ctl.useShamt ? deReg.shamt : opA[4:0];

	always_comb begin
		case (deReg.ctl.aluOp)
			ALU_ADD: aluOut = opA + opB;
			ALU_SUB: aluOut = opA - opB;
			ALU_AND: aluOut = opA & opB;
			ALU_OR: aluOut = opA | opB;
			ALU_XOR: aluOut = opA ^ opB;
			ALU_NOR: aluOut = ~(opA | opB);
			ALU_SLT: aluOut = {31'd0, $signed(opA) < $signed(opB)};
			ALU_SLTU: aluOut = {31'd0, opA < opB};
			ALU_SLL: aluOut = opB << shiftAmt;
			ALU_SRL: aluOut = opB >> shiftAmt;
			ALU_SRA: aluOut = $signed(opB) >>> shiftAmt;
			ALU_LUI: aluOut = {opB[15:0], 16'h0000};
			ALU_PASSB: aluOut = opB;
			default: aluOut = '0;
		endcase
	end

	assign execResult = aluOut;
	assign execDst = deReg.dst;
	assign execWrite = deReg.valid && deReg.ctl.regWrite;

	// execute/writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			retire <= '0;
		end else begin
			retire.valid <= deReg.valid;
			retire.pc <= deReg.pc;
			retire.wen <= deReg.valid && deReg.ctl.regWrite && !deReg.reserved
				&& deReg.dst != '0;
			retire.waddr <= deReg.dst;
			retire.wdata <= aluOut;
			retire.reserved <= deReg.valid && deReg.reserved;
		end
	end

endmodule

// File: src/fetchStage.sv
module fetchStage (
	input logic clk,
	input logic rst,
	input logic redirect,
	input mipsPkg::word_t target,
	input mipsPkg::word_t imemData,
	output mipsPkg::word_t imemAddr,
	output mipsPkg::fetchData_t fetchOut
);
	import mipsPkg::*;

	word_t pc;
	word_t pcNext;

	// redirect from decode replaces the sequential pc
	assign pcNext = redirect ? target : pc + 32'd4;
	assign imemAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= pcNext;
		end
	end

	// fetch/decode register
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchOut.valid <= 1'b0;
			fetchOut.pc <= RESET_PC;
			fetchOut.instr <= NOP_WORD;
		end else begin
			fetchOut.valid <= 1'b1;
			fetchOut.pc <= pc;
			fetchOut.instr <= imemData;
		end
	end

endmodule

// File: src/forwardUnit.sv
module forwardUnit (
	input mipsPkg::regAddr_t rs,
	input mipsPkg::regAddr_t rt,
	input mipsPkg::regAddr_t execDst,
	input logic execWrite,
	input mipsPkg::retire_t retireIn,
	output mipsPkg::fwdSel_t fwdSelA,
	output mipsPkg::fwdSel_t fwdSelB
);
	import mipsPkg::*;

	// younger producer in execute wins over the retiring one
	function automatic fwdSel_t pickSource(
		input regAddr_t src,
		input regAddr_t exDst,
		input logic exWrite,
		input retire_t wb
	);
		fwdSel_t sel;
		sel = FWD_REG;
		if (src != '0 && exWrite && exDst == src) begin
			sel = FWD_EXEC;
		end else if (src != '0 && wb.wen && wb.waddr == src) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	assign fwdSelA = pickSource(rs, execDst, execWrite, retireIn);
	assign fwdSelB = pickSource(rt, execDst, execWrite, retireIn);

endmodule

// File: src/mainDecoder.sv
module mainDecoder (
	input mipsPkg::word_t instr,
	output mipsPkg::ctl_t ctl
);
	import mipsPkg::*;

	op_t op;
	func_t func;

	assign op = instr[31:26];
	assign func = instr[5:0];

	always_comb begin
		ctl = CTL_IDLE;
		case (op)
			OP_SPECIAL: begin
				ctl.regWrite = 1'b1;
				case (func)
					FN_ADDU: ctl.aluOp = ALU_ADD;
					FN_SUBU: ctl.aluOp = ALU_SUB;
					FN_AND: ctl.aluOp = ALU_AND;
					FN_OR: ctl.aluOp = ALU_OR;
					FN_XOR: ctl.aluOp = ALU_XOR;
					FN_NOR: ctl.aluOp = ALU_NOR;
					FN_SLT: ctl.aluOp = ALU_SLT;
					FN_SLTU: ctl.aluOp = ALU_SLTU;
					FN_SLL: begin
						ctl.aluOp = ALU_SLL;
						ctl.useShamt = 1'b1;
					end
					FN_SRL: begin
						ctl.aluOp = ALU_SRL;
						ctl.useShamt = 1'b1;
					end
					FN_SRA: begin
						ctl.aluOp = ALU_SRA;
						ctl.useShamt = 1'b1;
					end
					FN_JR: begin
						ctl.regWrite = 1'b0;
						ctl.jr = 1'b1;
					end
					default: ctl = CTL_RESERVED;
				endcase
			end
			OP_J: ctl.jump = 1'b1;
			OP_JAL: begin
				// link value rides through the alu as operand b
				ctl.jump = 1'b1;
				ctl.link = 1'b1;
				ctl.regWrite = 1'b1;
				ctl.aluOp = ALU_PASSB;
			end
			OP_BEQ: ctl.branchType = BR_EQ;
			OP_BNE: ctl.branchType = BR_NE;
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctl.useImm = 1'b1;
				ctl.regWrite = 1'b1;
				ctl.dstIsRt = 1'b1;
				ctl.zeroExt = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
				case (op)
					OP_SLTI: ctl.aluOp = ALU_SLT;
					OP_ANDI: ctl.aluOp = ALU_AND;
					OP_ORI: ctl.aluOp = ALU_OR;
					OP_XORI: ctl.aluOp = ALU_XOR;
					OP_LUI: ctl.aluOp = ALU_LUI;
					default: ctl.aluOp = ALU_ADD;
				endcase
			end
			default: ctl = CTL_RESERVED;
		endcase
	end

endmodule

// File: src/mipsCore.sv
module mipsCore (
	input logic clk,
	input logic rst,
	output mipsPkg::word_t imemAddr,
	input mipsPkg::word_t imemData,
	output mipsPkg::retire_t retire
);
	import mipsPkg::*;

	fetchData_t fetchData;
	decodeData_t decodeData;
	logic redirect;
	word_t target;
	regAddr_t rs;
	regAddr_t rt;
	word_t regA;
	word_t regB;
	fwdSel_t fwdSelA;
	fwdSel_t fwdSelB;
	regAddr_t execDst;
	logic execWrite;
	word_t execResult;

	fetchStage u_fetch (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.target(target),
		.imemData(imemData),
		.imemAddr(imemAddr),
		.fetchOut(fetchData)
	);

	decodeStage u_decode (
		.clk(clk),
		.rst(rst),
		.fetchIn(fetchData),
		.rs(rs),
		.rt(rt),
		.regA(regA),
		.regB(regB),
		.fwdSelA(fwdSelA),
		.fwdSelB(fwdSelB),
		.execResult(execResult),
		.retireIn(retire),
		.redirect(redirect),
		.target(target),
		.decodeOut(decodeData)
	);

	// writeback goes straight from the retire port
	regFile u_regFile (
		.clk(clk),
		.rst(rst),
		.ra1(rs),
		.ra2(rt),
		.rd1(regA),
		.rd2(regB),
		.wrIn(retire)
	);

	forwardUnit u_forward (
		.rs(rs),
		.rt(rt),
		.execDst(execDst),
		.execWrite(execWrite),
		.retireIn(retire),
		.fwdSelA(fwdSelA),
		.fwdSelB(fwdSelB)
	);

	executeStage u_execute (
		.clk(clk),
		.rst(rst),
		.decodeIn(decodeData),
		.execDst(execDst),
		.execWrite(execWrite),
		.execResult(execResult),
		.retire(retire)
	);

endmodule

// File: src/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [5:0] op_t;
	typedef logic [5:0] func_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_PASSB
	} aluOp_t;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE
	} branchType_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EXEC,
		FWD_WB
	} fwdSel_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic useImm;
		logic zeroExt;
		logic useShamt;
		logic regWrite;
		logic dstIsRt;
		branchType_t branchType;
		logic jump;
		logic jr;
		logic link;
		logic reserved;
	} ctl_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instr;
	} fetchData_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		ctl_t ctl;
		word_t srcA;
		word_t srcB;
		word_t extImm;
		logic [4:0] shamt;
		regAddr_t dst;
		logic reserved;
	} decodeData_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		logic wen;
		regAddr_t waddr;
		word_t wdata;
		logic reserved;
	} retire_t;

	localparam word_t RESET_PC = 32'h0000_0000;
	localparam word_t NOP_WORD = 32'h0000_0000;
	localparam regAddr_t LINK_REG = 5'd31;

	// primary opcodes
	localparam op_t OP_SPECIAL = 6'h00;
	localparam op_t OP_J = 6'h02;
	localparam op_t OP_JAL = 6'h03;
	localparam op_t OP_BEQ = 6'h04;
	localparam op_t OP_BNE = 6'h05;
	localparam op_t OP_ADDIU = 6'h09;
	localparam op_t OP_SLTI = 6'h0a;
	localparam op_t OP_ANDI = 6'h0c;
	localparam op_t OP_ORI = 6'h0d;
	localparam op_t OP_XORI = 6'h0e;
	localparam op_t OP_LUI = 6'h0f;

	// function field under OP_SPECIAL
	localparam func_t FN_SLL = 6'h00;
	localparam func_t FN_SRL = 6'h02;
	localparam func_t FN_SRA = 6'h03;
	localparam func_t FN_JR = 6'h08;
	localparam func_t FN_ADDU = 6'h21;
	localparam func_t FN_SUBU = 6'h23;
	localparam func_t FN_AND = 6'h24;
	localparam func_t FN_OR = 6'h25;
	localparam func_t FN_XOR = 6'h26;
	localparam func_t FN_NOR = 6'h27;
	localparam func_t FN_SLT = 6'h2a;
	localparam func_t FN_SLTU = 6'h2b;

	// decoder starting point, nothing enabled
	localparam ctl_t CTL_IDLE = '{
		aluOp: ALU_ADD, useImm: 1'b0, zeroExt: 1'b0, useShamt: 1'b0,
		regWrite: 1'b0, dstIsRt: 1'b0, branchType: BR_NONE, jump: 1'b0,
		jr: 1'b0, link: 1'b0, reserved: 1'b0
	};

	// reserved instruction, no write, no redirect
	localparam ctl_t CTL_RESERVED = '{
		aluOp: ALU_ADD, useImm: 1'b0, zeroExt: 1'b0, useShamt: 1'b0,
		regWrite: 1'b0, dstIsRt: 1'b0, branchType: BR_NONE, jump: 1'b0,
		jr: 1'b0, link: 1'b0, reserved: 1'b1
	};

endpackage

// File: src/regFile.sv
module regFile (
	input logic clk,
	input logic rst,
	input mipsPkg::regAddr_t ra1,
	input mipsPkg::regAddr_t ra2,
	output mipsPkg::word_t rd1,
	output mipsPkg::word_t rd2,
	input mipsPkg::retire_t wrIn
);
	import mipsPkg::*;

	// r0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrIn.wen && wrIn.waddr != '0) begin
			regs[wrIn.waddr] <= wrIn.wdata;
		end
	end

	// write-through on a same-cycle write
	assign rd1 = (ra1 == '0) ? '0 :
		(wrIn.wen && wrIn.waddr == ra1) ? wrIn.wdata : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 :
		(wrIn.wen && wrIn.waddr == ra2) ? wrIn.wdata : regs[ra2];

endmodule

// File: tb.f
src/mipsPkg.sv
src/fetchStage.sv
src/mainDecoder.sv
src/forwardUnit.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/mipsCore.sv
verification/mipsCore_sva.sv
verification/tbMipsCore.sv

// File: verification/mipsCore_sva.sv
module mipsCore_sva (
	input logic clk,
	input logic rst,
	input mipsPkg::retire_t retire,
	input logic redirect,
	input mipsPkg::fetchData_t fetchData
);

	// a write belongs to a retiring instruction and never targets r0
	wenQualified: assert property (@(posedge clk) disable iff (rst)
		retire.wen |-> (retire.valid && retire.waddr != 5'd0))
		else $error("retire.wen without valid or with waddr zero");

	redirectNeedsFetch: assert property (@(posedge clk) disable iff (rst)
		redirect |-> fetchData.valid)
		else $error("redirect raised with an empty fetch/decode register");

	// nothing retires in reset or in the cycles right after it
	quietInReset: assert property (@(posedge clk) rst |=> !retire.valid)
		else $error("retire.valid during reset");

	quietAfterRelease: assert property (@(posedge clk) $fell(rst) |-> ##1 !retire.valid)
		else $error("retire.valid one cycle after reset release");

endmodule

bind mipsCore mipsCore_sva u_sva (
	.clk(clk),
	.rst(rst),
	.retire(retire),
	.redirect(redirect),
	.fetchData(fetchData)
);

// File: verification/tbMipsCore.sv
module tbMipsCore;
	import mipsPkg::*;

	localparam int MEM_WORDS = 512;
	localparam int RANDOM_COUNT = 300;
	localparam logic [31:0] LFSR_SEED = 32'h97df4e8c;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic clk;
	logic rst;
	word_t imemAddr;
	word_t imemData;
	retire_t retire;

	word_t prog [0:MEM_WORDS-1];
	int progLen;
	int randomStart;
	logic [31:0] lfsrState;

	// isa model state
	word_t mPc;
	word_t mRegs [0:31];
	logic mPendValid;
	word_t mPendTarget;

	retire_t expected;
	int relCycles;
	int cycleCount;
	int endCycle;
	logic modelDone;

	mipsCore u_dut (
		.clk(clk),
		.rst(rst),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.retire(retire)
	);

	always #5 clk = ~clk;

	// words past the program read as nop
	function automatic word_t fetchWord(input word_t addr);
		return (addr[31:2] < 30'(progLen)) ? prog[addr[10:2]] : NOP_WORD;
	endfunction

	always_comb imemData = fetchWord(imemAddr);

	function automatic logic lfsrBit();
		logic b;
		b = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (b) begin
			lfsrState = lfsrState ^ LFSR_TAPS;
		end
		return b;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrBit()};
		end
		return v;
	endfunction

	function automatic word_t encR(input func_t fn, input regAddr_t rs, input regAddr_t rt,
		input regAddr_t rd, input logic [4:0] sa);
		return {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t encI(input op_t op, input regAddr_t rs, input regAddr_t rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encJ(input op_t op, input int wordIdx);
		return {op, 26'(wordIdx)};
	endfunction

	task automatic emit(input word_t w);
		prog[progLen] = w;
		progLen++;
	endtask

	task automatic buildDirected();
		int b;
		// constant building and back-to-back dependencies
		emit(encI(OP_LUI, 5'd0, 5'd1, 16'h1234));
		emit(encI(OP_ORI, 5'd1, 5'd1, 16'h5678));
		emit(encR(FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
		emit(encR(FN_SUBU, 5'd2, 5'd1, 5'd3, 5'd0));
		emit(encR(FN_XOR, 5'd3, 5'd1, 5'd4, 5'd0));
		emit(encR(FN_NOR, 5'd4, 5'd0, 5'd5, 5'd0));
		emit(encR(FN_AND, 5'd5, 5'd2, 5'd6, 5'd0));
		emit(encR(FN_OR, 5'd6, 5'd3, 5'd7, 5'd0));
		emit(encR(FN_SLT, 5'd5, 5'd1, 5'd8, 5'd0));
		emit(encR(FN_SLTU, 5'd5, 5'd1, 5'd9, 5'd0));
		emit(encI(OP_ADDIU, 5'd0, 5'd10, 16'hfffb));
		emit(encI(OP_SLTI, 5'd10, 5'd11, 16'hfffd));
		emit(encI(OP_ANDI, 5'd5, 5'd12, 16'hf0f0));
		emit(encI(OP_XORI, 5'd12, 5'd13, 16'hffff));
		emit(encR(FN_SLL, 5'd0, 5'd1, 5'd14, 5'd4));
		emit(encR(FN_SRL, 5'd0, 5'd10, 5'd15, 5'd3));
		emit(encR(FN_SRA, 5'd0, 5'd10, 5'd16, 5'd3));
		// r0 destination
		emit(encI(OP_ADDIU, 5'd1, 5'd0, 16'h0007));
		// reserved opcode then reserved function
		emit(32'hfc00_0000);
		emit(encR(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0));
		emit(encR(FN_ADDU, 5'd16, 5'd14, 5'd17, 5'd0));
		b = progLen;
		// call the subroutine at b+11 and return to b+2
		emit(encJ(OP_JAL, b + 11));
		emit(encI(OP_ADDIU, 5'd0, 5'd18, 16'h0001));
		emit(encI(OP_ADDIU, 5'd31, 5'd19, 16'h0000));
		emit(encI(OP_BEQ, 5'd18, 5'd18, 16'h0002));
		emit(encI(OP_ADDIU, 5'd0, 5'd20, 16'h0002));
		emit(encI(OP_ADDIU, 5'd0, 5'd20, 16'h0063));
		// not taken with r20 forwarded from execute
		emit(encI(OP_BEQ, 5'd20, 5'd18, 16'h0002));
		emit(encI(OP_ADDIU, 5'd0, 5'd21, 16'h0003));
		emit(encI(OP_ADDIU, 5'd21, 5'd21, 16'h0004));
		emit(encJ(OP_J, b + 14));
		emit(encI(OP_ADDIU, 5'd0, 5'd22, 16'h0005));
		emit(encI(OP_ADDIU, 5'd23, 5'd23, 16'h0001));
		emit(encR(FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
		emit(encR(FN_ADDU, 5'd31, 5'd19, 5'd24, 5'd0));
		emit(encR(FN_SLL, 5'd0, 5'd24, 5'd25, 5'd2));
		emit(encI(OP_BNE, 5'd25, 5'd0, 16'h0002));
		emit(encR(FN_ADDU, 5'd25, 5'd24, 5'd26, 5'd0));
		emit(encI(OP_ADDIU, 5'd0, 5'd26, 16'h0063));
		emit(encR(FN_ADDU, 5'd26, 5'd25, 5'd27, 5'd0));
	endtask

	task automatic buildRandom(input int count);
		word_t w;
		logic [3:0] kind;
		regAddr_t rsR;
		regAddr_t rtR;
		regAddr_t rdR;
		logic [15:0] imm;
		logic [4:0] sa;
		logic [1:0] sel;
		logic lastCtl;
		logic isCtl;
		lastCtl = 1'b0;
		for (int i = 0; i < count; i++) begin
			kind = 4'(randBits(4));
			rsR = 5'(randBits(3));
			rtR = 5'(randBits(3));
			rdR = 5'(randBits(3));
			imm = 16'(randBits(16));
			sa = 5'(randBits(5));
			sel = 2'(randBits(2));
			// no control transfer in a delay slot
			if (lastCtl && (kind == 4'd13 || kind == 4'd14)) begin
				kind = 4'd9;
			end
			isCtl = (kind == 4'd13) || (kind == 4'd14);
			case (kind)
				4'd0: w = encR(FN_ADDU, rsR, rtR, rdR, 5'd0);
				4'd1: w = encR(FN_SUBU, rsR, rtR, rdR, 5'd0);
				4'd2: w = encR(FN_AND, rsR, rtR, rdR, 5'd0);
				4'd3: w = encR(FN_OR, rsR, rtR, rdR, 5'd0);
				4'd4: w = encR(FN_XOR, rsR, rtR, rdR, 5'd0);
				4'd5: w = encR(FN_NOR, rsR, rtR, rdR, 5'd0);
				4'd6: w = encR(FN_SLT, rsR, rtR, rdR, 5'd0);
				4'd7: w = encR(FN_SLTU, rsR, rtR, rdR, 5'd0);
				4'd8: w = encR(sel == 2'd0 ? FN_SLL : (sel == 2'd1 ? FN_SRL : FN_SRA),
					5'd0, rtR, rdR, sa);
				4'd10: w = encI(OP_SLTI, rsR, rtR, imm);
				4'd11: w = encI(sel == 2'd0 ? OP_ANDI : (sel == 2'd1 ? OP_ORI : OP_XORI),
					rsR, rtR, imm);
				4'd12: w = encI(OP_LUI, 5'd0, rtR, imm);
				// forward only by 2 to 5 words
				4'd13: w = encI(sel[0] ? OP_BNE : OP_BEQ, rsR, rtR, 16'(sa[1:0]) + 16'd1);
				4'd14: w = encJ(sel[0] ? OP_JAL : OP_J, progLen + 2 + int'(sa[1:0]));
				default: w = encI(OP_ADDIU, rsR, rtR, imm);
			endcase
			emit(w);
			lastCtl = isCtl;
		end
	endtask

	// steps the isa model by one instruction and returns the expected retire
	function automatic retire_t refStep();
		word_t instr;
		word_t a;
		word_t b;
		word_t sImm;
		word_t zImm;
		word_t res;
		word_t brTarget;
		word_t seqPc;
		word_t nextPc;
		logic [4:0] sa;
		regAddr_t dst;
		logic writes;
		logic isRes;
		logic taken;
		retire_t exp;
		instr = fetchWord(mPc);
		a = mRegs[instr[25:21]];
		b = mRegs[instr[20:16]];
		sa = instr[10:6];
		sImm = {{16{instr[15]}}, instr[15:0]};
		zImm = {16'h0000, instr[15:0]};
		seqPc = mPc + 32'd4;
		res = '0;
		brTarget = '0;
		dst = instr[20:16];
		writes = 1'b1;
		isRes = 1'b0;
		taken = 1'b0;
		case (instr[31:26])
			OP_SPECIAL: begin
				dst = instr[15:11];
				case (instr[5:0])
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND: res = a & b;
					FN_OR: res = a | b;
					FN_XOR: res = a ^ b;
					FN_NOR: res = ~(a | b);
					FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
					FN_SLTU: res = {31'd0, a < b};
					FN_SLL: res = b << sa;
					FN_SRL: res = b >> sa;
					FN_SRA: res = $signed(b) >>> sa;
					FN_JR: begin
						writes = 1'b0;
						taken = 1'b1;
						brTarget = a;
					end
					default: begin
						writes = 1'b0;
						isRes = 1'b1;
					end
				endcase
			end
			OP_J, OP_JAL: begin
				writes = (instr[31:26] == OP_JAL);
				dst = 5'd31;
				res = mPc + 32'd8;
				taken = 1'b1;
				brTarget = {seqPc[31:28], instr[25:0], 2'b00};
			end
			OP_BEQ, OP_BNE: begin
				writes = 1'b0;
				taken = (instr[31:26] == OP_BEQ) ? (a == b) : (a != b);
				brTarget = seqPc + (sImm << 2);
			end
			OP_ADDIU: res = a + sImm;
			OP_SLTI: res = {31'd0, $signed(a) < $signed(sImm)};
			OP_ANDI: res = a & zImm;
			OP_ORI: res = a | zImm;
			OP_XORI: res = a ^ zImm;
			OP_LUI: res = {instr[15:0], 16'h0000};
			default: begin
				writes = 1'b0;
				isRes = 1'b1;
			end
		endcase
		exp.valid = 1'b1;
		exp.pc = mPc;
		exp.wen = writes && (dst != 5'd0);
		exp.waddr = dst;
		exp.wdata = res;
		exp.reserved = isRes;
		if (exp.wen) begin
			mRegs[dst] = res;
		end
		// the delay slot runs before a pending target is taken
		nextPc = mPendValid ? mPendTarget : seqPc;
		mPendValid = taken;
		mPendTarget = brTarget;
		mPc = nextPc;
		return exp;
	endfunction

	task automatic checkEqual(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic compareRetire(input retire_t exp);
		string tag;
		tag = (exp.pc < word_t'(randomStart * 4)) ? "directed" : "random";
		checkEqual($sformatf("%s valid", tag), 32'd1, 32'(retire.valid));
		checkEqual($sformatf("%s pc", tag), exp.pc, retire.pc);
		checkEqual($sformatf("%s wen at %h", tag, exp.pc), 32'(exp.wen), 32'(retire.wen));
		checkEqual($sformatf("%s reserved at %h", tag, exp.pc), 32'(exp.reserved),
			32'(retire.reserved));
		if (exp.wen) begin
			checkEqual($sformatf("%s waddr at %h", tag, exp.pc), 32'(exp.waddr),
				32'(retire.waddr));
			checkEqual($sformatf("%s wdata at %h", tag, exp.pc), exp.wdata, retire.wdata);
		end
	endtask

	task automatic finishRun();
		$display("Simulation PASSED");
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		progLen = 0;
		relCycles = 0;
		cycleCount = 0;
		endCycle = 0;
		modelDone = 1'b0;
		lfsrState = LFSR_SEED;
		for (int i = 0; i < 32; i++) begin
			mRegs[i] = '0;
		end
		mPc = RESET_PC;
		mPendValid = 1'b0;
		mPendTarget = '0;
		buildDirected();
		randomStart = progLen;
		buildRandom(RANDOM_COUNT);
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
	end

	// first retire is due on the 4th edge after release
	always @(posedge clk) begin
		if (!rst) begin
			relCycles++;
			if (relCycles <= 3) begin
				checkEqual("idle after reset", 32'd0, 32'(retire.valid));
			end else begin
				expected = refStep();
				compareRetire(expected);
				if (!modelDone && mPc >= word_t'(progLen * 4)) begin
					modelDone = 1'b1;
					endCycle = relCycles + 3;
				end
				if (modelDone && relCycles >= endCycle) begin
					finishRun();
				end
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > 4 * progLen + 20) begin
			$display("timeout: the model never got past the program end in %0d cycles",
				cycleCount - 1);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

endmodule
